// File: flist.f
+incdir+source
source/fixed_pkg.sv
source/raster_pkg.sv
source/vertex_if.sv
source/triangle_intake.sv
source/vertex_lane.sv
source/triangle_collector.sv
source/vertex_stage_top.sv
tb/vertex_stage_tb.sv

// File: Bender.yml
package:
  name: vertex_stage

sources:
  - include_dirs:
      - source
    files:
      - source/fixed_pkg.sv
      - source/raster_pkg.sv
      - source/vertex_if.sv
      - source/triangle_intake.sv
      - source/vertex_lane.sv
      - source/triangle_collector.sv
      - source/vertex_stage_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/vertex_stage_tb.sv

// File: tb/vertex_stage_tb.sv
// Testbench for the vertex stage top level; runs a table of triangles through a reference model.
`timescale 1ns/1ns
`default_nettype none
`include "vertex_macros.svh"

module vertex_stage_tb;
    import fixed_pkg::*;
    import raster_pkg::*;

    localparam int   max_cases  = 40;
    localparam int   wait_limit = 60;
    localparam fix_t one        = 32'sh0001_0000;
    localparam fix_t half       = 32'sh0000_8000;
    localparam fix_t scale_x    = 32'sh0140_0000;
    localparam fix_t scale_y    = 32'sh00f0_0000;
    localparam fix_t identity [16] = '{one, 0, 0, 0, 0, one, 0, 0, 0, 0, one, 0, 0, 0, 0, one};

    logic   clock;
    logic   reset;
    logic   input_data_valid;
    logic   done_in;
    logic   stall_in;
    fix_t   vertex_x [`LANE_COUNT];
    fix_t   vertex_y [`LANE_COUNT];
    fix_t   vertex_z [`LANE_COUNT];
    fix_t   normal [3];
    fix_t   light [3];
    color_t color_in [`LANE_COUNT];
    fix_t   matrix [16];
    fix_t   x_out [`LANE_COUNT];
    fix_t   y_out [`LANE_COUNT];
    fix_t   z_out [`LANE_COUNT];
    fix_t   w_out [`LANE_COUNT];
    color_t color_out [`LANE_COUNT];
    logic   out_data_valid;
    logic   done_out;
    logic   stall_out;

    // ========================================================================
    // case table
    // ========================================================================

    string  tab_name [max_cases];
    fix_t   tab_matrix [max_cases][16];
    fix_t   tab_vx [max_cases][`LANE_COUNT];
    fix_t   tab_vy [max_cases][`LANE_COUNT];
    fix_t   tab_vz [max_cases][`LANE_COUNT];
    fix_t   tab_normal [max_cases][3];
    fix_t   tab_light [max_cases][3];
    color_t tab_color [max_cases][`LANE_COUNT];
    logic   tab_done [max_cases];
    int     tab_stall [max_cases];
    int     num_cases = 0;

    fix_t   new_matrix [16];
    fix_t   new_vx [`LANE_COUNT];
    fix_t   new_vy [`LANE_COUNT];
    fix_t   new_vz [`LANE_COUNT];
    fix_t   new_normal [3];
    fix_t   new_light [3];
    color_t new_color [`LANE_COUNT];

    integer seed = 75883;
    int     expected_q [$];
    int     stall_left = 0;
    int     error_count = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    logic   timed_out = 1'b0;
    logic   was_stalled = 1'b0;
    fix_t   snap_x [`LANE_COUNT];
    fix_t   snap_y [`LANE_COUNT];
    fix_t   snap_z [`LANE_COUNT];
    fix_t   snap_w [`LANE_COUNT];
    color_t snap_color [`LANE_COUNT];
    logic   snap_done;

    vertex_stage_top vertex_stage_top_inst (
        .clock            (clock),
        .reset            (reset),
        .input_data_valid (input_data_valid),
        .done_in          (done_in),
        .vertex_x         (vertex_x),
        .vertex_y         (vertex_y),
        .vertex_z         (vertex_z),
        .normal           (normal),
        .light            (light),
        .color_in         (color_in),
        .matrix           (matrix),
        .stall_in         (stall_in),
        .x_out            (x_out),
        .y_out            (y_out),
        .z_out            (z_out),
        .w_out            (w_out),
        .color_out        (color_out),
        .out_data_valid   (out_data_valid),
        .done_out         (done_out),
        .stall_out        (stall_out)
    );

    always #50 clock = ~clock;

    task automatic add_case(input string name, input logic done, input int stall);
        tab_name[num_cases]   = name;
        tab_matrix[num_cases] = new_matrix;
        tab_vx[num_cases]     = new_vx;
        tab_vy[num_cases]     = new_vy;
        tab_vz[num_cases]     = new_vz;
        tab_normal[num_cases] = new_normal;
        tab_light[num_cases]  = new_light;
        tab_color[num_cases]  = new_color;
        tab_done[num_cases]   = done;
        tab_stall[num_cases]  = stall;
        num_cases++;
    endtask

    task automatic build_table();
        new_matrix = identity;
        new_vx     = '{one, -4 * one, 10 * one};
        new_vy     = '{2 * one, 5 * one, -20 * one};
        new_vz     = '{3 * one, 0, one};
        new_normal = '{one, 0, 0};
        new_light  = '{one, 0, 0};
        new_color  = '{24'h102030, 24'hff8001, 24'h00ff7f};
        add_case("identity", 1'b1, 0);
        // odd fractions make the arithmetic shift truncate toward minus infinity.
        new_matrix = '{2 * one, 0, 0, -(3 * one + one / 4), 0, half, 0, 7 * one + half,
                       0, 0, one + half, 32'sh0000_1999, 0, 0, 0, one};
        new_vx     = '{-5 * one, 32'sh0001_8001, -32'sh0000_0003};
        new_vy     = '{3 * one, -32'sh0002_4001, 32'sh0000_0001};
        new_vz     = '{one, 32'sh0000_0007, -(10 * one + 1)};
        add_case("translate_scale", 1'b0, 0);
        new_matrix = identity;
        new_normal = '{0, one, 0};
        new_light  = '{0, one, 0};
        new_color  = '{24'hffffff, 24'h123456, 24'h80017f};
        add_case("shade_parallel", 1'b0, 0);
        new_light  = '{one, 0, 0};
        add_case("shade_perpendicular", 1'b1, 0);
        new_normal = '{0, 0, one};
        new_light  = '{0, 0, half};
        new_color  = '{24'hff7f01, 24'h030507, 24'h808080};
        add_case("shade_half", 1'b0, 0);
        new_vx = '{-one, half, 7 * one};
        add_case("burst_a", 1'b1, 0);
        new_vy = '{one, -half, 3 * one};
        add_case("burst_b", 1'b0, 0);
        new_vz = '{-2 * one, 0, half};
        add_case("burst_c", 1'b1, 0);
        add_case("stall_hold", 1'b0, 5);
        new_vx = '{4 * one, -8 * one, half};
        add_case("after_stall_a", 1'b1, 0);
        add_case("after_stall_b", 1'b0, 0);
        // the random triangles share one matrix so that they can stream back to back.
        for (int i = 0; i < 16; i++) begin
            new_matrix[i] = $random(seed) % (2 * one);
        end
        new_normal = '{half, half, 0};
        for (int k = 0; k < 20; k++) begin
            for (int v = 0; v < `LANE_COUNT; v++) begin
                new_vx[v]    = $random(seed) % (8 * one);
                new_vy[v]    = $random(seed) % (8 * one);
                new_vz[v]    = $random(seed) % (8 * one);
                new_color[v] = color_t'($random(seed));
            end
            new_light[0] = $unsigned($random(seed)) % 32'd65537;
            new_light[1] = $unsigned($random(seed)) % 32'd65537;
            new_light[2] = $random(seed);
            add_case($sformatf("random_%0d", k), $random(seed) & 1, $unsigned($random(seed)) % 3);
        end
    endtask

    // ========================================================================
    // reference model
    // ========================================================================

    function automatic fix_t fixed_product(input fix_t a, input fix_t b);
        longint full;
        full = longint'(a) * longint'(b);
        return fix_t'(full >>> 16);
    endfunction

    // row 0..3 gives the viewport x, y, z and w of vertex v.
    function automatic fix_t expected_coord(input int idx, input int v, input int row);
        fix_t pos [3];
        fix_t clip;
        fix_t scale;
        pos[0] = tab_vx[idx][v];
        pos[1] = tab_vy[idx][v];
        pos[2] = tab_vz[idx][v];
        scale  = (row == 1 || row == 3) ? scale_y : scale_x;
        clip   = fixed_product(tab_matrix[idx][4 * row + 3], one);
        for (int c = 0; c < 3; c++) begin
            clip = clip + fixed_product(tab_matrix[idx][4 * row + c], pos[c]);
        end
        return fixed_product(clip, scale) + scale;
    endfunction

    function automatic color_t expected_color(input int idx, input int v);
        fix_t   cosine;
        fix_t   channel_fix;
        fix_t   scaled;
        color_t result;
        cosine = 0;
        for (int k = 0; k < 3; k++) begin
            cosine = cosine + fixed_product(tab_normal[idx][k], tab_light[idx][k]);
        end
        for (int ch = 0; ch < 3; ch++) begin
            channel_fix = fix_t'({8'd0, tab_color[idx][v][8 * ch +: 8], 16'd0});
            scaled = fixed_product(channel_fix, cosine);
            result[8 * ch +: 8] = scaled[23:16];
        end
        return result;
    endfunction

    // ========================================================================
    // checking and driving
    // ========================================================================

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_triangle(input int idx);
        int errors_before;
        errors_before = error_count;
        for (int v = 0; v < `LANE_COUNT; v++) begin
            check_value(tab_name[idx], $sformatf("x_out[%0d]", v), expected_coord(idx, v, 0),
                        x_out[v]);
            check_value(tab_name[idx], $sformatf("y_out[%0d]", v), expected_coord(idx, v, 1),
                        y_out[v]);
            check_value(tab_name[idx], $sformatf("z_out[%0d]", v), expected_coord(idx, v, 2),
                        z_out[v]);
            check_value(tab_name[idx], $sformatf("w_out[%0d]", v), expected_coord(idx, v, 3),
                        w_out[v]);
            check_value(tab_name[idx], $sformatf("color_out[%0d]", v), expected_color(idx, v),
                        color_out[v]);
        end
        check_value(tab_name[idx], "done_out", tab_done[idx], done_out);
        if (error_count == errors_before) begin
            $display("result %-20s ok", tab_name[idx]);
            pass_count++;
        end else begin
            $display("result %-20s mismatch", tab_name[idx]);
            fail_count++;
        end
    endtask

    task automatic check_held();
        for (int v = 0; v < `LANE_COUNT; v++) begin
            check_value("stall_hold", "x_out held", snap_x[v], x_out[v]);
            check_value("stall_hold", "y_out held", snap_y[v], y_out[v]);
            check_value("stall_hold", "z_out held", snap_z[v], z_out[v]);
            check_value("stall_hold", "w_out held", snap_w[v], w_out[v]);
            check_value("stall_hold", "color_out held", snap_color[v], color_out[v]);
        end
        check_value("stall_hold", "out_data_valid held", 1'b1, out_data_valid);
        check_value("stall_hold", "done_out held", snap_done, done_out);
    endtask

    // one clock cycle: check what is on the outputs, then drive case idx or a bubble.
    task automatic tick(input int idx, output logic accepted);
        logic stall;
        @(negedge clock);
        stall = 1'b0;
        if (was_stalled) begin
            check_held();
        end
        if (out_data_valid && stall_left > 0) begin
            stall = 1'b1;
            stall_left--;
        end
        if (out_data_valid && !stall) begin
            if (expected_q.size() == 0) begin
                $display("an output triangle appeared while none was pending");
                error_count++;
            end else begin
                compare_triangle(expected_q.pop_front());
            end
        end
        snap_x      = x_out;
        snap_y      = y_out;
        snap_z      = z_out;
        snap_w      = w_out;
        snap_color  = color_out;
        snap_done   = done_out;
        was_stalled = out_data_valid && stall;
        stall_in         = stall;
        input_data_valid = (idx >= 0);
        if (idx >= 0) begin
            vertex_x = tab_vx[idx];
            vertex_y = tab_vy[idx];
            vertex_z = tab_vz[idx];
            normal   = tab_normal[idx];
            light    = tab_light[idx];
            color_in = tab_color[idx];
            matrix   = tab_matrix[idx];
            done_in  = tab_done[idx];
        end
        accepted = (idx >= 0) && !(out_data_valid && stall);
        if (accepted) begin
            expected_q.push_back(idx);
            stall_left += tab_stall[idx];
        end
        #1;
        // a stall is only ever applied to a presented triangle, so it must reach upstream.
        check_value("flow_control", "stall_out", stall, stall_out);
    endtask

    task automatic drain();
        int   waited;
        logic accepted;
        waited = 0;
        while (expected_q.size() > 0 && !timed_out) begin
            tick(-1, accepted);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: out_data_valid never brought %0d pending triangles",
                         expected_q.size());
                timed_out = 1'b1;
            end
        end
    endtask

    // the matrix is not registered in the lanes, so it only changes on an empty pipeline.
    task automatic send_case(input int idx);
        int   waited;
        logic accepted;
        if (matrix != tab_matrix[idx]) begin
            drain();
        end
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && !timed_out) begin
            tick(idx, accepted);
            waited++;
            if (!accepted && waited > wait_limit) begin
                $display("timeout: triangle %s was never accepted", tab_name[idx]);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        logic accepted;
        clock            = 1'b0;
        reset            = 1'b0;
        input_data_valid = 1'b0;
        done_in          = 1'b0;
        stall_in         = 1'b0;
        vertex_x         = '{default: '0};
        vertex_y         = '{default: '0};
        vertex_z         = '{default: '0};
        normal           = '{default: '0};
        light            = '{default: '0};
        color_in         = '{default: '0};
        matrix           = '{default: '0};
        build_table();
        repeat (10) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        check_value("reset", "out_data_valid", 1'b0, out_data_valid);
        check_value("reset", "done_out", 1'b0, done_out);
        check_value("reset", "stall_out", 1'b0, stall_out);
        for (int idx = 0; idx < num_cases; idx++) begin
            if (!timed_out) begin
                send_case(idx);
            end
        end
        drain();
        if (!timed_out) begin
            tick(-1, accepted);
            check_value("drain", "out_data_valid", 1'b0, out_data_valid);
        end
        $display("tests ok %0d, tests mismatched %0d, errors %0d", pass_count, fail_count,
                 error_count);
        if (error_count == 0 && fail_count == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/vertex_stage_top.sv
// Vertex stage top level; wires the intake, the vertex lanes and the collector together.
`timescale 1ns/1ns
`default_nettype none
`include "vertex_macros.svh"

module vertex_stage_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                input_data_valid,
    input  logic                done_in,
    input  fixed_pkg::fix_t     vertex_x [`LANE_COUNT],
    input  fixed_pkg::fix_t     vertex_y [`LANE_COUNT],
    input  fixed_pkg::fix_t     vertex_z [`LANE_COUNT],
    input  fixed_pkg::fix_t     normal [3],
    input  fixed_pkg::fix_t     light [3],
    input  raster_pkg::color_t  color_in [`LANE_COUNT],
    input  fixed_pkg::fix_t     matrix [16],
    input  logic                stall_in,
    output fixed_pkg::fix_t     x_out [`LANE_COUNT],
    output fixed_pkg::fix_t     y_out [`LANE_COUNT],
    output fixed_pkg::fix_t     z_out [`LANE_COUNT],
    output fixed_pkg::fix_t     w_out [`LANE_COUNT],
    output raster_pkg::color_t  color_out [`LANE_COUNT],
    output logic                out_data_valid,
    output logic                done_out,
    output logic                stall_out
);
    import fixed_pkg::*;

    logic advance;
    fix_t lane_w [`LANE_COUNT];

    vertex_if lane_in [`LANE_COUNT] ();
    vertex_if lane_out [`LANE_COUNT] ();

    triangle_intake triangle_intake_inst (
        .clock            (clock),
        .reset            (reset),
        .advance          (advance),
        .input_data_valid (input_data_valid),
        .done_in          (done_in),
        .vertex_x         (vertex_x),
        .vertex_y         (vertex_y),
        .vertex_z         (vertex_z),
        .normal           (normal),
        .light            (light),
        .color_in         (color_in),
        .lanes            (lane_in)
    );

    for (genvar i = 0; i < `LANE_COUNT; i++) begin : g_lane
        vertex_lane vertex_lane_inst (
            .clock   (clock),
            .reset   (reset),
            .advance (advance),
            .matrix  (matrix),
            .vin     (lane_in[i]),
            .vout    (lane_out[i]),
            .w       (lane_w[i])
        );
    end

    triangle_collector triangle_collector_inst (
        .clock          (clock),
        .reset          (reset),
        .stall_in       (stall_in),
        .lanes          (lane_out),
        .lane_w         (lane_w),
        .advance        (advance),
        .stall_out      (stall_out),
        .x_out          (x_out),
        .y_out          (y_out),
        .z_out          (z_out),
        .w_out          (w_out),
        .color_out      (color_out),
        .out_data_valid (out_data_valid),
        .done_out       (done_out)
    );

endmodule

`default_nettype wire

// File: source/triangle_collector.sv
// Output stage: joins the lane results into one triangle and drives the pipeline advance.
`timescale 1ns/1ns
`default_nettype none
`include "vertex_macros.svh"

module triangle_collector (
    input  logic                clock,
    input  logic                reset,
    input  logic                stall_in,
    vertex_if.sink              lanes [`LANE_COUNT],
    input  fixed_pkg::fix_t     lane_w [`LANE_COUNT],
    output logic                advance,
    output logic                stall_out,
    output fixed_pkg::fix_t     x_out [`LANE_COUNT],
    output fixed_pkg::fix_t     y_out [`LANE_COUNT],
    output fixed_pkg::fix_t     z_out [`LANE_COUNT],
    output fixed_pkg::fix_t     w_out [`LANE_COUNT],
    output raster_pkg::color_t  color_out [`LANE_COUNT],
    output logic                out_data_valid,
    output logic                done_out
);
    import raster_pkg::*;

    collect_state_t state;
    collect_state_t state_next;

    // =========================================================================
    // flow control
    // =========================================================================

    // only a triangle that is being presented can be held back.
    assign advance   = !(out_data_valid && stall_in);
    assign stall_out = !advance;

    // the lanes move in lock step, so lane 0 speaks for the whole triangle.
    always_comb begin
        state_next = state;
        case (state)
            collect_idle: begin
                if (advance && lanes[0].valid) begin
                    state_next = collect_hold;
                end
            end
            collect_hold: begin
                if (advance && !lanes[0].valid) begin
                    state_next = collect_idle;
                end
            end
            default: state_next = collect_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= collect_idle;
            done_out <= 1'b0;
        end else begin
            state <= state_next;
            if (advance) begin
                done_out <= lanes[0].done;
            end
        end
    end

    // a triangle is presented exactly while the collector holds one.
    assign out_data_valid = (state == collect_hold);

    // =========================================================================
    // triangle registers
    // =========================================================================

    for (genvar i = 0; i < `LANE_COUNT; i++) begin : g_vertex

        always_ff @(posedge clock) begin
            if (advance) begin
                x_out[i]     <= lanes[i].x;
                y_out[i]     <= lanes[i].y;
                z_out[i]     <= lanes[i].z;
                w_out[i]     <= lane_w[i];
                color_out[i] <= lanes[i].color;
            end
        end

        a_vertex_held: assert property (
            @(posedge clock) disable iff (!reset)
            out_data_valid && stall_in |=> $stable(x_out[i]) && $stable(y_out[i])
                && $stable(z_out[i]) && $stable(w_out[i]) && $stable(color_out[i])
        );

        // lane 0 stands in for the triangle, so every other lane must agree with it.
        a_lanes_lockstep: assert property (
            @(posedge clock) disable iff (!reset)
            lanes[i].valid == lanes[0].valid && lanes[i].done == lanes[0].done
        );

    end

    a_flags_held: assert property (
        @(posedge clock) disable iff (!reset)
        out_data_valid && stall_in |=> out_data_valid && $stable(done_out)
    );

endmodule

`default_nettype wire

// File: source/vertex_lane.sv
// One vertex lane: matrix transform, viewport map and Lambert shading, one register stage.
`timescale 1ns/1ns
`default_nettype none
`include "vertex_macros.svh"

module vertex_lane (
    input  logic             clock,
    input  logic             reset,
    input  logic             advance,
    input  fixed_pkg::fix_t  matrix [16],
    vertex_if.sink           vin,
    vertex_if.source         vout,
    output fixed_pkg::fix_t  w
);
    import fixed_pkg::*;
    import raster_pkg::*;

    localparam fix_t unity       = fix_t'(1 << `FRAC_BITS);
    localparam fix_t view_width  = fix_t'(`VIEW_WIDTH << `FRAC_BITS);
    localparam fix_t view_height = fix_t'(`VIEW_HEIGHT << `FRAC_BITS);
    // scale per clip row in x, y, z, w order.
    localparam fix_t view_scale [4] = '{view_width, view_height, view_width, view_height};

    fix_t     pos [3];
    fix_t     coef [4][3];
    fix_t     clip [4];
    fix_t     view [4];
    fix_t     channel_fix [channel_count];
    wide_t    shade_prod [channel_count];
    channel_t shade [channel_count];
    color_t   shaded;

    assign pos = '{vin.x, vin.y, vin.z};

    // matrix is row-major; the homogeneous w of the input vertex is one.
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 3; c++) begin
                coef[r][c] = matrix[4*r + c];
            end
            clip[r] = fix_dot3(coef[r], pos) + fix_mul(matrix[4*r + 3], unity);
            view[r] = fix_mul(clip[r], view_scale[r]) + view_scale[r];
        end
    end

    // the integer byte of the shifted product sits 2*FRAC_BITS up in the raw product.
    always_comb begin
        for (int c = 0; c < channel_count; c++) begin
            channel_fix[c] = fix_t'(vin.color[8*c +: 8]) << `FRAC_BITS;
            shade_prod[c]  = wide_t'(channel_fix[c]) * wide_t'(vin.cosine);
            shade[c]       = shade_prod[c][2*`FRAC_BITS +: 8];
        end
    end

    assign shaded = {shade[2], shade[1], shade[0]};

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            vout.valid <= 1'b0;
            vout.done  <= 1'b0;
        end else if (advance) begin
            vout.valid <= vin.valid;
            vout.done  <= vin.done;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            vout.x      <= view[0];
            vout.y      <= view[1];
            vout.z      <= view[2];
            w           <= view[3];
            vout.cosine <= vin.cosine;
            vout.color  <= shaded;
        end
    end

    a_valid_known: assert property (
        @(posedge clock) disable iff (!reset)
        !$isunknown(vout.valid)
    );

endmodule

`default_nettype wire

// File: source/triangle_intake.sv
// Front stage of the vertex pipeline: takes one triangle and feeds one vertex to each lane.
`timescale 1ns/1ns
`default_nettype none
`include "vertex_macros.svh"

module triangle_intake (
    input  logic                clock,
    input  logic                reset,
    input  logic                advance,
    input  logic                input_data_valid,
    input  logic                done_in,
    input  fixed_pkg::fix_t     vertex_x [`LANE_COUNT],
    input  fixed_pkg::fix_t     vertex_y [`LANE_COUNT],
    input  fixed_pkg::fix_t     vertex_z [`LANE_COUNT],
    input  fixed_pkg::fix_t     normal [3],
    input  fixed_pkg::fix_t     light [3],
    input  raster_pkg::color_t  color_in [`LANE_COUNT],
    vertex_if.source            lanes [`LANE_COUNT]
);
    import fixed_pkg::*;

    fix_t cosine;

    // the Lambert factor is a property of the face, so it is shared by all three vertices.
    assign cosine = fix_dot3(normal, light);

    for (genvar i = 0; i < `LANE_COUNT; i++) begin : g_lane

        // an advancing edge with no valid input loads a bubble.
        always_ff @(posedge clock or negedge reset) begin
            if (!reset) begin
                lanes[i].valid <= 1'b0;
                lanes[i].done  <= 1'b0;
            end else if (advance) begin
                lanes[i].valid <= input_data_valid;
                lanes[i].done  <= done_in;
            end
        end

        always_ff @(posedge clock) begin
            if (advance) begin
                lanes[i].x      <= vertex_x[i];
                lanes[i].y      <= vertex_y[i];
                lanes[i].z      <= vertex_z[i];
                lanes[i].cosine <= cosine;
                lanes[i].color  <= color_in[i];
            end
        end

        // a frozen pipeline must not take in or drop a triangle, so the source holds it.
        a_input_held: assert property (
            @(posedge clock) disable iff (!reset)
            !advance && input_data_valid |=> input_data_valid && $stable(done_in)
                && $stable(vertex_x[i]) && $stable(vertex_y[i]) && $stable(vertex_z[i])
                && $stable(color_in[i])
        );

    end

endmodule

`default_nettype wire

// File: source/vertex_if.sv
// Grouped signals of one vertex between pipeline stages; source drives, sink reads.
`timescale 1ns/1ns
`default_nettype none

interface vertex_if;
    import fixed_pkg::*;
    import raster_pkg::*;

    logic   valid;
    logic   done;
    fix_t   x;
    fix_t   y;
    fix_t   z;
    // lighting factor, only read by the lanes.
    fix_t   cosine;
    color_t color;

    modport source (
        output valid,
        output done,
        output x,
        output y,
        output z,
        output cosine,
        output color
    );

    modport sink (
        input valid,
        input done,
        input x,
        input y,
        input z,
        input cosine,
        input color
    );

endinterface

`default_nettype wire

// File: source/raster_pkg.sv
// Pipeline-level types of the rasterizer (colors and collector states); import where needed.
`default_nettype none

package raster_pkg;

    // =========================================================================
    // color data
    // =========================================================================

    // packed RGB with red in the top byte and blue in the bottom byte.
    typedef logic [23:0] color_t;

    typedef logic [7:0] channel_t;

    // number of channels packed in one color_t.
    localparam int channel_count = 3;

    // =========================================================================
    // control
    // =========================================================================

    // the collector is in hold whenever it presents a triangle downstream.
    typedef enum logic {
        collect_idle,
        collect_hold
    } collect_state_t;

endpackage

`default_nettype wire

// File: source/fixed_pkg.sv
// Q16.16 fixed-point types and arithmetic shared by the vertex stage; import where needed.
`default_nettype none
`include "vertex_macros.svh"

package fixed_pkg;

    typedef logic signed [31:0] fix_t;
    typedef logic signed [63:0] wide_t;

    // full signed product, shifted back down to Q16.16 and truncated.
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        wide_t product;
        product = wide_t'(a) * wide_t'(b);
        return fix_t'(product >>> `FRAC_BITS);
    endfunction

    // each term is truncated before the sum, so the sum wraps at 32 bits.
    function automatic fix_t fix_dot3(input fix_t a [3], input fix_t b [3]);
        fix_t sum;
        sum = '0;
        for (int i = 0; i < 3; i++) begin
            sum = sum + fix_mul(a[i], b[i]);
        end
        return sum;
    endfunction

endpackage

`default_nettype wire

// File: source/vertex_macros.svh
// Vertex stage constants (fraction bits, lane count, viewport size); include where needed.
`ifndef VERTEX_MACROS_SVH
`define VERTEX_MACROS_SVH

// number of fraction bits in a Q16.16 value.
`define FRAC_BITS 16

// vertices per triangle, one lane each.
`define LANE_COUNT 3

// viewport size in whole pixels.
`define VIEW_WIDTH 320
`define VIEW_HEIGHT 240

`endif
